/* src.f */
+incdir+.
membus_pkg.sv
data_axi_master.sv
inst_axi_reader.sv
membus2axi.sv
tb_clock_gen.sv
tb_axi_mem.sv
tb_membus2axi.sv

/* Makefile */
TOP = tb_membus2axi

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f src.f --top-module $(TOP) -o sim

run: build
	@out=$$(./obj_dir/sim 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only +incdir+. membus_pkg.sv data_axi_master.sv \
		inst_axi_reader.sv membus2axi.sv --top-module membus2axi
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tb_membus2axi.sv */
`timescale 1ns/1ps
`include "membus_config.svh"

module tb_membus2axi
	import membus_pkg::*;
();

	localparam int TIMEOUT = 200;

	logic                           aclk, rst_n, hold_b;
	logic [`MEMBUS_ADDR_WIDTH-1:0]  awaddr, araddr, m0_araddr, rom_address, ram_address;
	logic [`MEMBUS_DATA_WIDTH-1:0]  wdata, rdata, m0_rdata, rom_rdata, ram_wdata, ram_rdata;
	logic [`MEMBUS_ID_WIDTH-1:0]    awid, wid, bid, arid, rid, m0_arid, m0_rid;
	logic [`MEMBUS_STRB_WIDTH-1:0]  wstrb, ram_wmask;
	logic [3:0]                     awlen, arlen, m0_arlen;
	logic [2:0]                     awsize, arsize, m0_arsize;
	logic [1:0]                     awburst, arburst, m0_arburst, bresp, rresp, m0_rresp;
	logic                           awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic                           arvalid, arready, rlast, rvalid, rready;
	logic                           m0_arvalid, m0_arready, m0_rlast, m0_rvalid, m0_rready;
	logic                           rom_req, rom_addr_ok, rom_data_ok, rom_data_resp;
	logic                           ram_req, ram_re, ram_we, ram_addr_ok, ram_data_ok;
	logic                           ram_data_resp;

	tb_clock_gen u_clk (.*);
	tb_axi_mem u_mem (.*);
	membus2axi u_membus2axi (.*);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// word the memory model holds before any write
	function automatic logic [31:0] preload_word(input logic [31:0] addr);
		logic [7:0] idx;
		idx = addr[9:2];
		return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic timed_out(input string name, input string what);
		$display("%s: timed out waiting for %s", name, what);
		$display("Test failures found");
		$fatal(1, "stopped on a timeout");
	endtask

	task automatic ram_drive(input logic we, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] mask);
		@(posedge aclk);
		ram_req     <= 1'b1;
		ram_we      <= we;
		ram_re      <= !we;
		ram_address <= addr;
		ram_wdata   <= data;
		ram_wmask   <= mask;
	endtask

	task automatic rom_drive(input logic [31:0] addr);
		@(posedge aclk);
		rom_req     <= 1'b1;
		rom_address <= addr;
	endtask

	// returns on the edge that accepts the request
	task automatic wait_accept(input string name, input logic use_rom);
		int n;
		n = 0;
		@(negedge aclk);
		while (!(use_rom ? rom_addr_ok : ram_addr_ok)) begin
			n++;
			if (n > TIMEOUT)
				timed_out(name, "the port to accept the request");
			@(negedge aclk);
		end
		@(posedge aclk);
		if (use_rom) begin
			rom_req <= 1'b0;
		end else begin
			ram_req <= 1'b0;
			ram_we  <= 1'b0;
			ram_re  <= 1'b0;
		end
	endtask

	task automatic take_response(input string name, input logic use_rom, input int hold,
		output logic [31:0] data);
		int n;
		n = 0;
		@(negedge aclk);
		while (!(use_rom ? rom_data_ok : ram_data_ok)) begin
			n++;
			if (n > TIMEOUT)
				timed_out(name, "data_ok");
			@(negedge aclk);
		end
		data = use_rom ? rom_rdata : ram_rdata;
		// cpu not ready yet, everything must hold
		repeat (hold) begin
			@(negedge aclk);
			check({name, " data_ok held"}, 32'd1, 32'(use_rom ? rom_data_ok : ram_data_ok));
			check({name, " rdata held"}, data, use_rom ? rom_rdata : ram_rdata);
			check({name, " addr_ok low"}, 32'd0, 32'(use_rom ? rom_addr_ok : ram_addr_ok));
		end
		@(posedge aclk);
		if (use_rom)
			rom_data_resp <= 1'b1;
		else
			ram_data_resp <= 1'b1;
		@(posedge aclk);
		rom_data_resp <= 1'b0;
		ram_data_resp <= 1'b0;
		@(negedge aclk);
		check({name, " back to idle"}, 32'd1, 32'(use_rom ? rom_addr_ok : ram_addr_ok));
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic reset_state();
		@(negedge aclk);
		check("reset awvalid", 32'd0, 32'(awvalid));
		check("reset wvalid", 32'd0, 32'(wvalid));
		check("reset arvalid", 32'd0, 32'(arvalid));
		check("reset m0_arvalid", 32'd0, 32'(m0_arvalid));
		check("reset bready", 32'd0, 32'(bready));
		check("reset rready", 32'd0, 32'(rready));
		check("reset m0_rready", 32'd0, 32'(m0_rready));
		check("reset ram_data_ok", 32'd0, 32'(ram_data_ok));
		check("reset rom_data_ok", 32'd0, 32'(rom_data_ok));
		check("reset ram_addr_ok", 32'd1, 32'(ram_addr_ok));
		check("reset rom_addr_ok", 32'd1, 32'(rom_addr_ok));
	endtask

	task automatic write_read();
		logic [31:0] data;
		ram_drive(1'b1, 32'h40, 32'h1234abcd, 4'b1111);
		wait_accept("write_read", 1'b0);
		@(negedge aclk);
		check("write_read awvalid", 32'd1, 32'(awvalid));
		check("write_read wvalid", 32'd1, 32'(wvalid));
		check("write_read awid", `MEMBUS_DATA_ID, 32'(awid));
		check("write_read wstrb", 32'hf, 32'(wstrb));
		check("write_read awaddr", 32'h40, awaddr);
		check("write_read awlen", 32'd0, 32'(awlen));
		check("write_read awsize", `MEMBUS_AXI_SIZE, 32'(awsize));
		check("write_read awburst", `MEMBUS_AXI_BURST_INCR, 32'(awburst));
		check("write_read wdata", 32'h1234abcd, wdata);
		check("write_read wlast", 32'd1, 32'(wlast));
		check("write_read wid", `MEMBUS_DATA_ID, 32'(wid));
		take_response("write_read write", 1'b0, 0, data);
		ram_drive(1'b0, 32'h40, 32'h0, 4'h0);
		wait_accept("write_read", 1'b0);
		@(negedge aclk);
		check("write_read arvalid", 32'd1, 32'(arvalid));
		check("write_read arid", `MEMBUS_DATA_ID, 32'(arid));
		check("write_read araddr", 32'h40, araddr);
		check("write_read arlen", 32'd0, 32'(arlen));
		check("write_read arsize", `MEMBUS_AXI_SIZE, 32'(arsize));
		check("write_read arburst", `MEMBUS_AXI_BURST_INCR, 32'(arburst));
		take_response("write_read read", 1'b0, 0, data);
		check("write_read data", 32'h1234abcd, data);
	endtask

	task automatic byte_mask();
		logic [31:0] old_word;
		logic [31:0] data;
		old_word = preload_word(32'h80);
		ram_drive(1'b1, 32'h80, 32'hcafef00d, 4'b0101);
		wait_accept("byte_mask", 1'b0);
		take_response("byte_mask write", 1'b0, 0, data);
		ram_drive(1'b0, 32'h80, 32'h0, 4'h0);
		wait_accept("byte_mask", 1'b0);
		take_response("byte_mask read", 1'b0, 0, data);
		// bytes 0 and 2 are new
		check("byte_mask data", (32'hcafef00d & 32'h00ff00ff) | (old_word & 32'hff00ff00), data);
	endtask

	task automatic inst_fetch();
		logic [31:0] addr;
		logic [31:0] data;
		for (int k = 0; k < 6; k++) begin
			addr = 32'h100 + 32'(k) * 32'd4;
			rom_drive(addr);
			wait_accept("inst_fetch", 1'b1);
			@(negedge aclk);
			check("inst_fetch m0_arid", `MEMBUS_INST_ID, 32'(m0_arid));
			check("inst_fetch m0_araddr", addr, m0_araddr);
			check("inst_fetch m0_arlen", 32'd0, 32'(m0_arlen));
			check("inst_fetch m0_arsize", `MEMBUS_AXI_SIZE, 32'(m0_arsize));
			check("inst_fetch m0_arburst", `MEMBUS_AXI_BURST_INCR, 32'(m0_arburst));
			take_response("inst_fetch", 1'b1, 0, data);
			check("inst_fetch data", preload_word(addr), data);
		end
	endtask

	task automatic raw_hazard();
		logic [31:0] data;
		@(posedge aclk);
		hold_b <= 1'b1;
		ram_drive(1'b1, 32'h200, 32'h5eed1234, 4'hf);
		wait_accept("raw_hazard", 1'b0);
		rom_drive(32'h200);
		// fetch of the same word must wait for the b response
		repeat (10) begin
			@(negedge aclk);
			check("raw_hazard rom_addr_ok", 32'd0, 32'(rom_addr_ok));
			check("raw_hazard m0_arvalid", 32'd0, 32'(m0_arvalid));
		end
		@(posedge aclk);
		hold_b <= 1'b0;
		wait_accept("raw_hazard", 1'b1);
		take_response("raw_hazard write", 1'b0, 0, data);
		take_response("raw_hazard fetch", 1'b1, 0, data);
		check("raw_hazard data", 32'h5eed1234, data);
	endtask

	task automatic response_hold();
		logic [31:0] data;
		ram_drive(1'b0, 32'h300, 32'h0, 4'h0);
		wait_accept("response_hold", 1'b0);
		take_response("response_hold ram", 1'b0, 6, data);
		check("response_hold ram data", preload_word(32'h300), data);
		rom_drive(32'h304);
		wait_accept("response_hold", 1'b1);
		take_response("response_hold rom", 1'b1, 6, data);
		check("response_hold rom data", preload_word(32'h304), data);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int n;
		hold_b        <= 1'b0;
		rom_req       <= 1'b0;
		rom_address   <= '0;
		rom_data_resp <= 1'b0;
		ram_req       <= 1'b0;
		ram_re        <= 1'b0;
		ram_we        <= 1'b0;
		ram_address   <= '0;
		ram_wdata     <= '0;
		ram_wmask     <= '0;
		ram_data_resp <= 1'b0;
		n = 0;
		@(posedge aclk);
		while (rst_n !== 1'b1) begin
			n++;
			if (n > TIMEOUT)
				timed_out("reset", "the end of reset");
			@(posedge aclk);
		end
		reset_state();
		write_read();
		byte_mask();
		inst_fetch();
		raw_hazard();
		response_hold();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps
`include "membus_config.svh"

module tb_axi_mem (
	input  logic                            aclk,
	input  logic                            rst_n,
	// b response is kept back while high
	input  logic                            hold_b,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   awaddr, araddr, m0_araddr,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     awid, arid, m0_arid,
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   wdata,
	input  logic [`MEMBUS_STRB_WIDTH-1:0]   wstrb,
	input  logic                            awvalid, wvalid, bready, arvalid, rready,
	input  logic                            m0_arvalid, m0_rready,
	output logic                            awready, wready, arready, m0_arready,
	output logic                            bvalid, rvalid, m0_rvalid, rlast, m0_rlast,
	output logic [1:0]                      bresp, rresp, m0_rresp,
	output logic [`MEMBUS_ID_WIDTH-1:0]     bid, rid, m0_rid,
	output logic [`MEMBUS_DATA_WIDTH-1:0]   rdata, m0_rdata
);

	logic [`MEMBUS_DATA_WIDTH-1:0]  mem [0:255];
	logic [`MEMBUS_ADDR_WIDTH-1:0]  aw_addr_q;
	logic [`MEMBUS_ID_WIDTH-1:0]    aw_id_q;
	logic [`MEMBUS_DATA_WIDTH-1:0]  w_data_q;
	logic [`MEMBUS_STRB_WIDTH-1:0]  w_strb_q;
	logic                           aw_got;
	logic                           w_got;
	logic [31:0]                    dice;
	integer                         seed = 32'ha41f1df7;

	// every byte of the fill depends on the whole word index
	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] strb);
		logic [31:0] word;
		word = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				word[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return word;
	endfunction

	assign rlast    = 1'b1;
	assign m0_rlast = 1'b1;
	assign bresp    = 2'b00;
	assign rresp    = 2'b00;
	assign m0_rresp = 2'b00;

	always @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			arready    <= 1'b0;
			m0_arready <= 1'b0;
			bvalid     <= 1'b0;
			rvalid     <= 1'b0;
			m0_rvalid  <= 1'b0;
			aw_got     <= 1'b0;
			w_got      <= 1'b0;
			bid        <= '0;
			rid        <= '0;
			m0_rid     <= '0;
			rdata      <= '0;
			m0_rdata   <= '0;
			for (int i = 0; i < 256; i++) begin
				mem[i] <= fill_word(8'(i));
			end
		end else begin
			// readies high about three cycles in four
			dice = $random(seed);
			awready    <= dice[1:0] != 2'b00;
			wready     <= dice[3:2] != 2'b00;
			arready    <= dice[5:4] != 2'b00;
			m0_arready <= dice[7:6] != 2'b00;

			if (awvalid && awready) begin
				aw_addr_q <= awaddr;
				aw_id_q   <= awid;
				aw_got    <= 1'b1;
			end
			if (wvalid && wready) begin
				w_data_q <= wdata;
				w_strb_q <= wstrb;
				w_got    <= 1'b1;
			end
			// commit and answer once address and data are both in
			if (aw_got && w_got && !bvalid && !hold_b) begin
				mem[aw_addr_q[9:2]] <= merge_bytes(mem[aw_addr_q[9:2]], w_data_q, w_strb_q);
				bvalid <= 1'b1;
				bid    <= aw_id_q;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end

			if (arvalid && arready) begin
				rvalid <= 1'b1;
				rdata  <= mem[araddr[9:2]];
				rid    <= arid;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end

			if (m0_arvalid && m0_arready) begin
				m0_rvalid <= 1'b1;
				m0_rdata  <= mem[m0_araddr[9:2]];
				m0_rid    <= m0_arid;
			end else if (m0_rvalid && m0_rready) begin
				m0_rvalid <= 1'b0;
			end
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic aclk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (3) @(posedge aclk);
		rst_n <= 1'b1;
	end

endmodule

/* membus2axi.sv */
`timescale 1ns/1ps
`include "membus_config.svh"

module membus2axi (
	input  logic                            aclk,
	input  logic                            rst_n,
	// data master write address
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   awaddr,
	output logic [3:0]                      awlen,
	output logic [2:0]                      awsize,
	output logic [1:0]                      awburst,
	output logic [`MEMBUS_ID_WIDTH-1:0]     awid,
	output logic                            awvalid,
	input  logic                            awready,
	// data master write data
	output logic [`MEMBUS_DATA_WIDTH-1:0]   wdata,
	output logic [`MEMBUS_STRB_WIDTH-1:0]   wstrb,
	output logic                            wlast,
	output logic [`MEMBUS_ID_WIDTH-1:0]     wid,
	output logic                            wvalid,
	input  logic                            wready,
	// data master write response
	input  logic [1:0]                      bresp,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     bid,
	input  logic                            bvalid,
	output logic                            bready,
	// data master read address
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   araddr,
	output logic [3:0]                      arlen,
	output logic [2:0]                      arsize,
	output logic [1:0]                      arburst,
	output logic [`MEMBUS_ID_WIDTH-1:0]     arid,
	output logic                            arvalid,
	input  logic                            arready,
	// data master read data
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   rdata,
	input  logic [1:0]                      rresp,
	input  logic                            rlast,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     rid,
	input  logic                            rvalid,
	output logic                            rready,
	// instruction master read address
	output logic [`MEMBUS_ID_WIDTH-1:0]     m0_arid,
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   m0_araddr,
	output logic [3:0]                      m0_arlen,
	output logic [2:0]                      m0_arsize,
	output logic [1:0]                      m0_arburst,
	output logic                            m0_arvalid,
	input  logic                            m0_arready,
	// instruction master read data
	input  logic [`MEMBUS_ID_WIDTH-1:0]     m0_rid,
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   m0_rdata,
	input  logic [1:0]                      m0_rresp,
	input  logic                            m0_rlast,
	input  logic                            m0_rvalid,
	output logic                            m0_rready,
	// rom port
	input  logic                            rom_req,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   rom_address,
	output logic                            rom_addr_ok,
	output logic                            rom_data_ok,
	output logic [`MEMBUS_DATA_WIDTH-1:0]   rom_rdata,
	input  logic                            rom_data_resp,
	// ram port
	input  logic                            ram_req,
	input  logic                            ram_re,
	input  logic                            ram_we,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   ram_address,
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   ram_wdata,
	input  logic [`MEMBUS_STRB_WIDTH-1:0]   ram_wmask,
	output logic                            ram_addr_ok,
	output logic                            ram_data_ok,
	output logic [`MEMBUS_DATA_WIDTH-1:0]   ram_rdata,
	input  logic                            ram_data_resp
);

	// write in flight, seen by the fetch side
	logic                           writing;
	logic [`MEMBUS_ADDR_WIDTH-1:0]  last_write_address;

	//////////////////////////////////////////////////
	// data port master
	//////////////////////////////////////////////////

	data_axi_master u_data (
		.aclk(aclk), .rst_n(rst_n),
		.req(ram_req), .re(ram_re), .we(ram_we), .address(ram_address),
		.wdata(ram_wdata), .wmask(ram_wmask), .data_resp(ram_data_resp),
		.addr_ok(ram_addr_ok), .data_ok(ram_data_ok), .rdata(ram_rdata),
		.writing(writing), .last_write_address(last_write_address),
		.awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
		.awid(awid), .awvalid(awvalid), .awready(awready),
		.wdata_axi(wdata), .wstrb(wstrb), .wlast(wlast), .wid(wid),
		.wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bid(bid), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arid(arid), .arvalid(arvalid), .arready(arready),
		.rdata_axi(rdata), .rresp(rresp), .rlast(rlast), .rid(rid),
		.rvalid(rvalid), .rready(rready)
	);

	//////////////////////////////////////////////////
	// instruction port reader
	//////////////////////////////////////////////////

	inst_axi_reader u_inst (
		.aclk(aclk), .rst_n(rst_n),
		.req(rom_req), .address(rom_address), .data_resp(rom_data_resp),
		.addr_ok(rom_addr_ok), .data_ok(rom_data_ok), .rdata(rom_rdata),
		.writing(writing), .last_write_address(last_write_address),
		.araddr(m0_araddr), .arlen(m0_arlen), .arsize(m0_arsize),
		.arburst(m0_arburst), .arid(m0_arid), .arvalid(m0_arvalid),
		.arready(m0_arready),
		.rdata_axi(m0_rdata), .rresp(m0_rresp), .rlast(m0_rlast), .rid(m0_rid),
		.rvalid(m0_rvalid), .rready(m0_rready)
	);

endmodule

/* inst_axi_reader.sv */
`timescale 1ns/1ps
`include "membus_config.svh"

module inst_axi_reader
	import membus_pkg::*;
(
	input  logic                            aclk,
	input  logic                            rst_n,
	// rom port
	input  logic                            req,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   address,
	input  logic                            data_resp,
	output logic                            addr_ok,
	output logic                            data_ok,
	output logic [`MEMBUS_DATA_WIDTH-1:0]   rdata,
	// in-flight write from the data master
	input  logic                            writing,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   last_write_address,
	// read address channel
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   araddr,
	output logic [3:0]                      arlen,
	output logic [2:0]                      arsize,
	output logic [1:0]                      arburst,
	output logic [`MEMBUS_ID_WIDTH-1:0]     arid,
	output logic                            arvalid,
	input  logic                            arready,
	// read data channel
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   rdata_axi,
	input  logic [1:0]                      rresp,
	input  logic                            rlast,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     rid,
	input  logic                            rvalid,
	output logic                            rready
);

	localparam logic [`MEMBUS_ID_WIDTH-1:0] ID = `MEMBUS_INST_ID;

	inst_state_t                    state;
	logic [`MEMBUS_ADDR_WIDTH-1:0]  addr_q;
	logic                           blocked;
	logic                           accept;
	logic                           ar_hs;
	logic                           r_hs;

	// same word as a write still waiting for its b response
	assign blocked = writing &&
		(address[`MEMBUS_ADDR_WIDTH-1:2] == last_write_address[`MEMBUS_ADDR_WIDTH-1:2]);

	assign accept = req && addr_ok;
	assign ar_hs  = arvalid && arready;
	assign r_hs   = rvalid && rready && rlast && (rid == ID);

	//////////////////////////////////////////////////
	// fetch fsm
	//////////////////////////////////////////////////

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IS_IDLE;
		end else begin
			case (state)
				IS_IDLE: begin
					if (accept) begin
						state <= IS_AR;
					end
				end
				IS_AR: begin
					if (ar_hs) begin
						state <= IS_R;
					end
				end
				IS_R: begin
					if (r_hs) begin
						state <= IS_HOLD;
					end
				end
				IS_HOLD: begin
					// cpu has taken the word
					if (data_resp) begin
						state <= IS_IDLE;
					end
				end
				default: state <= IS_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			addr_q <= address;
		end
		if (r_hs) begin
			rdata <= rdata_axi;
		end
	end

	assign addr_ok = (state == IS_IDLE) && !blocked;
	assign data_ok = (state == IS_HOLD);

	assign araddr  = addr_q;
	assign arlen   = 4'd0;
	assign arsize  = 3'(`MEMBUS_AXI_SIZE);
	assign arburst = 2'(`MEMBUS_AXI_BURST_INCR);
	assign arid    = ID;
	assign arvalid = (state == IS_AR);
	assign rready  = (state == IS_R);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a fetch behind a matching write gets no ar
	a_raw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		(state == IS_IDLE) && req && blocked |=> !arvalid);

	a_arvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

/* data_axi_master.sv */
`timescale 1ns/1ps
`include "membus_config.svh"

module data_axi_master
	import membus_pkg::*;
(
	input  logic                            aclk,
	input  logic                            rst_n,
	// ram port
	input  logic                            req,
	input  logic                            re,
	input  logic                            we,
	input  logic [`MEMBUS_ADDR_WIDTH-1:0]   address,
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   wdata,
	input  logic [`MEMBUS_STRB_WIDTH-1:0]   wmask,
	input  logic                            data_resp,
	output logic                            addr_ok,
	output logic                            data_ok,
	output logic [`MEMBUS_DATA_WIDTH-1:0]   rdata,
	// write tracking for the fetch side
	output logic                            writing,
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   last_write_address,
	// write address channel
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   awaddr,
	output logic [3:0]                      awlen,
	output logic [2:0]                      awsize,
	output logic [1:0]                      awburst,
	output logic [`MEMBUS_ID_WIDTH-1:0]     awid,
	output logic                            awvalid,
	input  logic                            awready,
	// write data channel
	output logic [`MEMBUS_DATA_WIDTH-1:0]   wdata_axi,
	output logic [`MEMBUS_STRB_WIDTH-1:0]   wstrb,
	output logic                            wlast,
	output logic [`MEMBUS_ID_WIDTH-1:0]     wid,
	output logic                            wvalid,
	input  logic                            wready,
	// write response channel
	input  logic [1:0]                      bresp,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     bid,
	input  logic                            bvalid,
	output logic                            bready,
	// read address channel
	output logic [`MEMBUS_ADDR_WIDTH-1:0]   araddr,
	output logic [3:0]                      arlen,
	output logic [2:0]                      arsize,
	output logic [1:0]                      arburst,
	output logic [`MEMBUS_ID_WIDTH-1:0]     arid,
	output logic                            arvalid,
	input  logic                            arready,
	// read data channel
	input  logic [`MEMBUS_DATA_WIDTH-1:0]   rdata_axi,
	input  logic [1:0]                      rresp,
	input  logic                            rlast,
	input  logic [`MEMBUS_ID_WIDTH-1:0]     rid,
	input  logic                            rvalid,
	output logic                            rready
);

	localparam logic [`MEMBUS_ID_WIDTH-1:0] ID = `MEMBUS_DATA_ID;

	data_state_t                    state;
	data_op_t                       op_q;
	data_op_t                       req_op;
	logic [`MEMBUS_ADDR_WIDTH-1:0]  addr_q;
	logic [`MEMBUS_DATA_WIDTH-1:0]  wdata_q;
	logic [`MEMBUS_STRB_WIDTH-1:0]  wmask_q;
	logic                           aw_done;
	logic                           w_done;
	logic                           accept;
	logic                           aw_hs;
	logic                           w_hs;
	logic                           b_hs;
	logic                           ar_hs;
	logic                           r_hs;

	// we wins over re, a bare req is dropped
	assign accept = req && addr_ok && (we || re);
	assign req_op = we ? OP_WRITE : OP_READ;

	assign aw_hs = awvalid && awready;
	assign w_hs  = wvalid && wready;
	// responses are matched on our own id
	assign b_hs  = bvalid && bready && (bid == ID);
	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready && rlast && (rid == ID);

	//////////////////////////////////////////////////
	// control fsm
	//////////////////////////////////////////////////

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= DS_IDLE;
			op_q    <= OP_READ;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			case (state)
				DS_IDLE: begin
					if (accept) begin
						op_q    <= req_op;
						aw_done <= 1'b0;
						w_done  <= 1'b0;
						state   <= (req_op == OP_WRITE) ? DS_AW_W : DS_AR;
					end
				end
				DS_AW_W: begin
					// aw and w may complete in either order
					if (aw_hs) begin
						aw_done <= 1'b1;
					end
					if (w_hs) begin
						w_done <= 1'b1;
					end
					if ((aw_done || aw_hs) && (w_done || w_hs)) begin
						state <= DS_B;
					end
				end
				DS_B: begin
					if (b_hs) begin
						state <= DS_HOLD;
					end
				end
				DS_AR: begin
					if (ar_hs) begin
						state <= DS_R;
					end
				end
				DS_R: begin
					if (r_hs) begin
						state <= DS_HOLD;
					end
				end
				DS_HOLD: begin
					if (data_resp) begin
						state <= DS_IDLE;
					end
				end
				default: state <= DS_IDLE;
			endcase
		end
	end

	// request payload and read data
	always_ff @(posedge aclk) begin
		if (accept) begin
			addr_q  <= address;
			wdata_q <= wdata;
			wmask_q <= wmask;
		end
		if (r_hs) begin
			rdata <= rdata_axi;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	assign addr_ok = (state == DS_IDLE);
	assign data_ok = (state == DS_HOLD);

	assign writing = (op_q == OP_WRITE) && ((state == DS_AW_W) || (state == DS_B));
	assign last_write_address = addr_q;

	assign awaddr  = addr_q;
	assign awlen   = 4'd0;
	assign awsize  = 3'(`MEMBUS_AXI_SIZE);
	assign awburst = 2'(`MEMBUS_AXI_BURST_INCR);
	assign awid    = ID;
	assign awvalid = (state == DS_AW_W) && !aw_done;

	assign wdata_axi = wdata_q;
	assign wstrb     = wmask_q;
	assign wlast     = 1'b1;
	assign wid       = ID;
	assign wvalid    = (state == DS_AW_W) && !w_done;

	assign bready = (state == DS_B);

	assign araddr  = addr_q;
	assign arlen   = 4'd0;
	assign arsize  = 3'(`MEMBUS_AXI_SIZE);
	assign arburst = 2'(`MEMBUS_AXI_BURST_INCR);
	assign arid    = ID;
	assign arvalid = (state == DS_AR);

	assign rready = (state == DS_R);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_awvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr));

	a_ok_exclusive: assert property (@(posedge aclk) disable iff (!rst_n)
		!(data_ok && addr_ok));

endmodule

/* membus_pkg.sv */
package membus_pkg;

	//////////////////////////////////////////////////
	// data master
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		DS_IDLE,
		DS_AW_W,
		DS_B,
		DS_AR,
		DS_R,
		DS_HOLD
	} data_state_t;

	// kind of the accepted ram request
	typedef enum logic {
		OP_READ,
		OP_WRITE
	} data_op_t;

	//////////////////////////////////////////////////
	// instruction reader
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IS_IDLE,
		IS_AR,
		IS_R,
		IS_HOLD
	} inst_state_t;

endpackage

/* membus_config.svh */
`ifndef MEMBUS_CONFIG_SVH
`define MEMBUS_CONFIG_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

`define MEMBUS_DATA_WIDTH 32
`define MEMBUS_ADDR_WIDTH 32
`define MEMBUS_ID_WIDTH 6
// one strobe bit per data byte
`define MEMBUS_STRB_WIDTH 4

//////////////////////////////////////////////////
// fixed axi fields
//////////////////////////////////////////////////

// transaction ids per master
`define MEMBUS_DATA_ID 3
`define MEMBUS_INST_ID 9
// 4 bytes per beat
`define MEMBUS_AXI_SIZE 2
`define MEMBUS_AXI_BURST_INCR 1

`endif
